// File: Makefile
VERILATOR ?= verilator
TOP       := tb_eeprom_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) common/eeprom_params.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_model (
  input  wire scl,
  input  wire ack_en,  // low: device answers no byte
  inout  wire sda
);

  localparam int DEPTH  = 1 << `EE_ADDR_W;
  localparam int PAGE_W = `EE_ADDR_W - `EE_DATA_W;

  localparam int PH_IDLE = 0;
  localparam int PH_CTRL = 1;
  localparam int PH_WORD = 2;
  localparam int PH_DATA = 3;
  localparam int PH_SEND = 4;

  logic [`EE_DATA_W-1:0] mem [DEPTH];
  logic [`EE_DATA_W-1:0] rx;
  logic [`EE_DATA_W-1:0] tx;
  logic [`EE_DATA_W-1:0] word;
  logic [PAGE_W-1:0]     page;
  logic                  sda_low;
  logic                  scl_now;
  logic                  scl_q;
  logic                  sda_now;
  logic                  sda_q;
  logic                  master_nack;
  logic                  ok;
  int                    phase;
  int                    next_phase;
  int                    count;  // scl rises in this byte

  assign sda = sda_low ? 1'b0 : 1'bz;

  task automatic send_bit();
    sda_low = !tx[`EE_DATA_W-1];
    tx      = tx << 1;
  endtask

  task automatic load_next();
    tx    = mem[{page, word}];
    count = 0;
    send_bit();
  endtask

  // ack decision for a received byte, acts on the 8th falling edge
  task automatic take_byte();
    ok         = 1'b0;
    next_phase = PH_IDLE;
    case (phase)
      PH_CTRL: begin
        if (ack_en && rx[`EE_DATA_W-1 -: 4] == `EE_DEV_CODE) begin
          ok         = 1'b1;
          page       = rx[PAGE_W:1];
          next_phase = rx[0] ? PH_SEND : PH_WORD;
        end
      end
      PH_WORD: begin
        if (ack_en) begin
          ok         = 1'b1;
          word       = rx;
          next_phase = PH_DATA;
        end
      end
      PH_DATA: begin
        if (ack_en) begin
          ok              = 1'b1;
          mem[{page, word}] = rx;
          word            = word + 1'b1;
          next_phase      = PH_DATA;
        end
      end
      default: ;
    endcase
    sda_low = ok;
  endtask

  task automatic scl_fall();
    if (phase == PH_SEND) begin
      if (count < `EE_DATA_W)
        send_bit();
      else if (count == `EE_DATA_W)
        sda_low = 1'b0;  // master's ack slot
      else if (master_nack)
        phase = PH_IDLE;
      else begin
        word = word + 1'b1;
        load_next();
      end
    end else if (count == `EE_DATA_W) begin
      take_byte();
    end else if (count > `EE_DATA_W) begin
      sda_low = 1'b0;
      count   = 0;
      phase   = next_phase;
      if (phase == PH_SEND)
        load_next();
    end
  endtask

  initial begin
    sda_low     = 1'b0;
    scl_q       = 1'b1;
    sda_q       = 1'b1;
    phase       = PH_IDLE;
    next_phase  = PH_IDLE;
    count       = 0;
    page        = '0;
    word        = '0;
    rx          = '0;
    tx          = '0;
    master_nack = 1'b1;
    ok          = 1'b0;
    for (int i = 0; i < DEPTH; i++)
      mem[`EE_ADDR_W'(i)] = `EE_DATA_W'(i) ^ `EE_DATA_W'(i >> 3);  // all address bits count
    forever begin
      @(scl or sda);
      scl_now = (scl === 1'b1);
      sda_now = (sda !== 1'b0);
      if (scl_now && scl_q && sda_q && !sda_now) begin
        phase   = PH_CTRL;  // start or repeated start
        count   = 0;
        sda_low = 1'b0;
      end else if (scl_now && scl_q && !sda_q && sda_now) begin
        phase   = PH_IDLE;  // stop
        sda_low = 1'b0;
      end else if (scl_now && !scl_q && phase != PH_IDLE) begin
        if (count < `EE_DATA_W)
          rx = {rx[`EE_DATA_W-2:0], sda_now};
        else
          master_nack = sda_now;
        count = count + 1;
      end else if (!scl_now && scl_q && phase != PH_IDLE) begin
        scl_fall();
      end
      scl_q = scl_now;
      sda_q = sda_now;
    end
  end

endmodule

// File: bench/tb_eeprom_top.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module tb_eeprom_top;

  localparam int CLK_NS    = 40;
  localparam int SCL_CLKS  = 2 * `EE_SCL_HALF;
  localparam int READ_SCL  = 39;   // scl periods of one read
  localparam int N_TRANS   = 120;  // all tests together, rounded up
  localparam int ACK_LIMIT = 3 * READ_SCL * SCL_CLKS;
  localparam int DEPTH     = 1 << `EE_ADDR_W;
  localparam longint WATCHDOG_NS = longint'(N_TRANS) * READ_SCL * SCL_CLKS * CLK_NS * 2;

  logic                  clk;
  logic                  rst_n;
  logic                  wr;
  logic                  rd;
  logic [`EE_ADDR_W-1:0] addr;
  logic [`EE_DATA_W-1:0] wdata;
  logic                  drive_data;
  logic                  model_ack_en;
  wire  [`EE_DATA_W-1:0] data;
  wire                   ack;
  wire                   err;
  wire                   scl;
  wire                   sda;
  logic [`EE_DATA_W-1:0] ref_mem [DEPTH];
  integer                seed;

  assign data = drive_data ? wdata : {`EE_DATA_W{1'bz}};

  pullup (sda);
  for (genvar i = 0; i < `EE_DATA_W; i++) begin : g_data_pull
    pullup (data[i]);  // released bus reads all ones
  end

  eeprom_top i_eeprom_top (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .rd    (rd),
    .addr  (addr),
    .data  (data),
    .ack   (ack),
    .err   (err),
    .scl   (scl),
    .sda   (sda)
  );

  eeprom_model i_eeprom_model (
    .scl    (scl),
    .ack_en (model_ack_en),
    .sda    (sda)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    abort_run();
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // power-up content of the memory
  function automatic logic [`EE_DATA_W-1:0] fill_byte(input logic [`EE_ADDR_W-1:0] a);
    return a[`EE_DATA_W-1:0] ^ `EE_DATA_W'(a >> 3);
  endfunction

  task automatic wait_ack(output logic got_err, output logic [`EE_DATA_W-1:0] got_data);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (ack !== 1'b1) begin
      cycles++;
      if (cycles > ACK_LIMIT) begin
        $display("no ack within %0d cycles of the request", ACK_LIMIT);
        abort_run();
      end
      @(negedge clk);
    end
    got_err  = err;
    got_data = data;
  endtask

  task automatic do_write(input logic [`EE_ADDR_W-1:0] a, input logic [`EE_DATA_W-1:0] d,
                          output logic e);
    logic [`EE_DATA_W-1:0] unused;
    addr       = a;
    wdata      = d;
    drive_data = 1'b1;
    wr         = 1'b1;
    wait_ack(e, unused);
    wr         = 1'b0;
    drive_data = 1'b0;
    if (!e)
      ref_mem[a] = d;  // only bytes the model acknowledged
    @(negedge clk);
    check_value("ack", 0, 32'(ack));
  endtask

  task automatic do_read(input logic [`EE_ADDR_W-1:0] a, output logic [`EE_DATA_W-1:0] d,
                         output logic e);
    addr = a;
    rd   = 1'b1;
    wait_ack(e, d);
    rd   = 1'b0;
    @(negedge clk);
    check_value("ack", 0, 32'(ack));
  endtask

  task automatic read_expect(input logic [`EE_ADDR_W-1:0] a);
    logic [`EE_DATA_W-1:0] got;
    logic                  e;
    do_read(a, got, e);
    check_value("err", 0, 32'(e));
    check_value("data", 32'(ref_mem[a]), 32'(got));
  endtask

  task automatic reset_state_test();
    repeat (3) @(negedge clk);
    check_value("scl", 1, 32'(scl));
    check_value("sda", 1, 32'(sda));
    check_value("ack", 0, 32'(ack));
    check_value("err", 0, 32'(err));
    check_value("data", 32'({`EE_DATA_W{1'b1}}), 32'(data));
  endtask

  task automatic write_read_test();
    logic e;
    do_write(11'h155, 8'ha7, e);
    check_value("err", 0, 32'(e));
    read_expect(11'h155);
  endtask

  task automatic random_sweep();
    logic [`EE_ADDR_W-1:0] a;
    logic [`EE_ADDR_W-1:0] written[$];
    logic                  e;
    for (int n = 0; n < 32; n++) begin
      a = `EE_ADDR_W'($random(seed));
      do_write(a, `EE_DATA_W'($random(seed)), e);
      check_value("err", 0, 32'(e));
      read_expect(a);
      written.push_back(a);
    end
    foreach (written[k])
      read_expect(written[k]);
  endtask

  task automatic overwrite_test();
    logic [`EE_ADDR_W-1:0] base;
    logic [`EE_ADDR_W-1:0] other;
    logic                  e;
    base  = 11'h2c5;
    other = base ^ 11'h400;  // same low byte, other page
    do_write(base - 1'b1, 8'h11, e);
    check_value("err", 0, 32'(e));
    do_write(base, 8'h22, e);
    check_value("err", 0, 32'(e));
    do_write(base + 1'b1, 8'h33, e);
    check_value("err", 0, 32'(e));
    do_write(other, 8'h44, e);
    check_value("err", 0, 32'(e));
    do_write(base, 8'hd9, e);
    check_value("err", 0, 32'(e));
    read_expect(base);
    read_expect(base - 1'b1);
    read_expect(base + 1'b1);
    read_expect(other);
  endtask

  task automatic nack_test();
    logic [`EE_ADDR_W-1:0] a;
    logic [`EE_DATA_W-1:0] old;
    logic [`EE_DATA_W-1:0] got;
    logic                  e;
    a            = 11'h3a1;
    old          = ref_mem[a];
    model_ack_en = 1'b0;
    do_write(a, ~old, e);
    check_value("err", 1, 32'(e));
    do_read(a, got, e);
    check_value("err", 1, 32'(e));
    model_ack_en = 1'b1;
    do_read(a, got, e);
    check_value("err", 0, 32'(e));
    check_value("data", 32'(old), 32'(got));
  endtask

  task automatic both_levels_test();
    logic [`EE_ADDR_W-1:0] a;
    logic [`EE_DATA_W-1:0] d;
    logic [`EE_DATA_W-1:0] unused;
    logic                  e;
    a          = 11'h0f0;
    d          = ~ref_mem[a];
    addr       = a;
    wdata      = d;
    drive_data = 1'b1;
    wr         = 1'b1;
    rd         = 1'b1;
    wait_ack(e, unused);
    wr         = 1'b0;
    rd         = 1'b0;
    drive_data = 1'b0;
    check_value("err", 0, 32'(e));
    ref_mem[a] = d;
    @(negedge clk);
    read_expect(a);  // rd alone
  endtask

  initial begin
    seed         = 32'h4540;
    rst_n        = 1'b0;
    wr           = 1'b0;
    rd           = 1'b0;
    addr         = '0;
    wdata        = '0;
    drive_data   = 1'b0;
    model_ack_en = 1'b1;
    for (int i = 0; i < DEPTH; i++)
      ref_mem[`EE_ADDR_W'(i)] = fill_byte(`EE_ADDR_W'(i));
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    reset_state_test();
    write_read_test();
    random_sweep();
    overwrite_test();
    nack_test();
    both_levels_test();

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: common/eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// request side widths
`define EE_ADDR_W 11
`define EE_DATA_W 8

// 24C16 device type code, upper nibble of every control byte
`define EE_DEV_CODE 4'b1010

// clk cycles per scl half period, keep even
`define EE_SCL_HALF 4

`endif

// File: common/eeprom_pkg.sv
package eeprom_pkg;

  // request sequencer states, one hot
  typedef enum logic [9:0] {
    idle        = 10'b00_0000_0001,
    write_start = 10'b00_0000_0010,
    ctrl_write  = 10'b00_0000_0100,
    addr_write  = 10'b00_0000_1000,
    data_write  = 10'b00_0001_0000,
    read_start  = 10'b00_0010_0000,
    ctrl_read   = 10'b00_0100_0000,
    data_read   = 10'b00_1000_0000,
    stop        = 10'b01_0000_0000,
    ackn        = 10'b10_0000_0000
  } ctrl_state_e;

  // serial engine commands
  typedef enum logic [2:0] {
    cmd_start      = 3'd0,  // repeated start when the bus is already owned
    cmd_write_byte = 3'd1,
    cmd_read_byte  = 3'd2,
    cmd_stop       = 3'd3
  } bus_cmd_e;

endpackage

// File: hw/eeprom_top.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr,
  input  logic                  rd,
  input  logic [`EE_ADDR_W-1:0] addr,
  inout  wire  [`EE_DATA_W-1:0] data,
  output logic                  ack,
  output logic                  err,
  output logic                  scl,
  inout  wire                   sda
);

  eeprom_pkg::bus_cmd_e  cmd;
  logic                  cmd_valid;
  logic [`EE_DATA_W-1:0] tx_byte;
  logic                  done;
  logic                  nack;
  logic [`EE_DATA_W-1:0] rx_byte;

  eeprom_wr i_eeprom_wr (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (wr),
    .rd        (rd),
    .addr      (addr),
    .data      (data),
    .ack       (ack),
    .err       (err),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .tx_byte   (tx_byte),
    .done      (done),
    .nack      (nack),
    .rx_byte   (rx_byte)
  );

  serial_engine i_serial_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .tx_byte   (tx_byte),
    .done      (done),
    .nack      (nack),
    .rx_byte   (rx_byte),
    .scl       (scl),
    .sda       (sda)  // pulled up outside
  );

endmodule

// File: hw/eeprom_wr/eeprom_wr.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_wr (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr,
  input  logic                  rd,
  input  logic [`EE_ADDR_W-1:0] addr,
  inout  wire  [`EE_DATA_W-1:0] data,
  output logic                  ack,
  output logic                  err,
  output eeprom_pkg::bus_cmd_e  cmd,
  output logic                  cmd_valid,
  output logic [`EE_DATA_W-1:0] tx_byte,
  input  logic                  done,
  input  logic                  nack,
  input  logic [`EE_DATA_W-1:0] rx_byte
);

  localparam int PAGE_W = `EE_ADDR_W - `EE_DATA_W;

  eeprom_pkg::ctrl_state_e state;
  eeprom_pkg::ctrl_state_e next_state;

  logic                  waiting;    // command out, engine busy
  logic                  is_read;
  logic                  nack_flag;  // sticky over sent bytes
  logic                  hold;       // last request still raised
  logic                  data_oe;
  logic                  accept;
  logic                  byte_nack;
  logic [PAGE_W-1:0]     page;
  logic [`EE_ADDR_W-1:0] addr_q;
  logic [`EE_DATA_W-1:0] wdata_q;
  logic [`EE_DATA_W-1:0] rdata_q;

  assign accept    = (state == eeprom_pkg::idle) && !hold && (wr || rd);
  assign byte_nack = done && nack && (cmd == eeprom_pkg::cmd_write_byte);
  assign page      = addr_q[`EE_ADDR_W-1 -: PAGE_W];  // a10..a8 go in the control byte

  assign data = (data_oe && rd) ? rdata_q : {`EE_DATA_W{1'bz}};

  // command and byte for the current bus phase
  always_comb begin
    cmd     = eeprom_pkg::cmd_stop;
    tx_byte = wdata_q;
    case (state)
      eeprom_pkg::write_start,
      eeprom_pkg::read_start: cmd = eeprom_pkg::cmd_start;
      eeprom_pkg::ctrl_write: begin
        cmd     = eeprom_pkg::cmd_write_byte;
        tx_byte = {`EE_DEV_CODE, page, 1'b0};
      end
      eeprom_pkg::addr_write: begin
        cmd     = eeprom_pkg::cmd_write_byte;
        tx_byte = addr_q[`EE_DATA_W-1:0];
      end
      eeprom_pkg::data_write: begin
        cmd     = eeprom_pkg::cmd_write_byte;
        tx_byte = wdata_q;
      end
      eeprom_pkg::ctrl_read: begin
        cmd     = eeprom_pkg::cmd_write_byte;
        tx_byte = {`EE_DEV_CODE, page, 1'b1};
      end
      eeprom_pkg::data_read: cmd = eeprom_pkg::cmd_read_byte;
      default: ;
    endcase
  end

  // taken when the engine reports done
  always_comb begin
    next_state = state;
    case (state)
      eeprom_pkg::write_start: next_state = eeprom_pkg::ctrl_write;
      eeprom_pkg::ctrl_write:
        next_state = nack ? eeprom_pkg::stop : eeprom_pkg::addr_write;
      eeprom_pkg::addr_write: begin
        if (nack)
          next_state = eeprom_pkg::stop;  // give up, still close the bus
        else if (is_read)
          next_state = eeprom_pkg::read_start;
        else
          next_state = eeprom_pkg::data_write;
      end
      eeprom_pkg::data_write:  next_state = eeprom_pkg::stop;
      eeprom_pkg::read_start:  next_state = eeprom_pkg::ctrl_read;
      eeprom_pkg::ctrl_read:
        next_state = nack ? eeprom_pkg::stop : eeprom_pkg::data_read;
      eeprom_pkg::data_read:   next_state = eeprom_pkg::stop;
      eeprom_pkg::stop:        next_state = eeprom_pkg::ackn;
      default:                 next_state = eeprom_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= eeprom_pkg::idle;
      waiting   <= 1'b0;
      cmd_valid <= 1'b0;
      is_read   <= 1'b0;
      nack_flag <= 1'b0;
      hold      <= 1'b0;
      data_oe   <= 1'b0;
      ack       <= 1'b0;
      err       <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      ack       <= 1'b0;
      err       <= 1'b0;
      if (!rd)
        data_oe <= 1'b0;  // release once the reader lets go

      case (state)
        eeprom_pkg::idle: begin
          if (hold) begin
            if (!wr && !rd)
              hold <= 1'b0;
          end else if (accept) begin
            is_read   <= !wr;  // write wins when both are high
            nack_flag <= 1'b0;
            state     <= eeprom_pkg::write_start;
          end
        end
        eeprom_pkg::ackn: begin
          ack     <= 1'b1;
          err     <= nack_flag;
          data_oe <= is_read;
          hold    <= 1'b1;
          state   <= eeprom_pkg::idle;
        end
        default: begin
          if (!waiting) begin
            cmd_valid <= 1'b1;
            waiting   <= 1'b1;
          end else if (done) begin
            waiting <= 1'b0;
            if (byte_nack)
              nack_flag <= 1'b1;
            state <= next_state;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= addr;
      wdata_q <= data;
    end
    if (state == eeprom_pkg::data_read && done)
      rdata_q <= rx_byte;
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    ack |=> !ack)
    else $error("eeprom_wr: ack longer than one cycle, state %s", state.name());

  a_err_ack: assert property (@(posedge clk) disable iff (!rst_n)
    err |-> ack)
    else $error("eeprom_wr: err without ack");

  // read data goes away the cycle after rd drops
  a_data_release: assert property (@(posedge clk) disable iff (!rst_n)
    !rd |=> !data_oe)
    else $error("eeprom_wr: data bus held after rd fell");

endmodule

// File: hw/eeprom_wr/serial_engine.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module serial_engine (
  input  logic                  clk,
  input  logic                  rst_n,
  input  eeprom_pkg::bus_cmd_e  cmd,
  input  logic                  cmd_valid,
  input  logic [`EE_DATA_W-1:0] tx_byte,
  output logic                  done,
  output logic                  nack,
  output logic [`EE_DATA_W-1:0] rx_byte,
  output logic                  scl,
  inout  wire                   sda
);

  localparam int PERIOD = 2 * `EE_SCL_HALF;
  localparam int QTR    = `EE_SCL_HALF / 2;
  localparam int CNT_W  = $clog2(PERIOD);
  localparam int BIT_W  = $clog2(`EE_DATA_W + 1);

  // points inside one scl period, scl low in the first half
  localparam logic [CNT_W-1:0] DRIVE_PT  = CNT_W'(QTR);
  localparam logic [CNT_W-1:0] RISE_PT   = CNT_W'(`EE_SCL_HALF);
  localparam logic [CNT_W-1:0] SAMPLE_PT = CNT_W'(`EE_SCL_HALF + QTR);
  localparam logic [CNT_W-1:0] LAST_PT   = CNT_W'(PERIOD - 1);

  eeprom_pkg::bus_cmd_e  mode;
  logic                  busy;
  logic [CNT_W-1:0]      cnt;       // clk count within scl period
  logic [BIT_W-1:0]      bit_cnt;   // 0..7 data, 8 is the ack bit
  logic [`EE_DATA_W-1:0] shift;
  logic                  sda_low;
  logic                  is_byte;
  logic                  last_bit;

  assign is_byte  = (mode == eeprom_pkg::cmd_write_byte) ||
                    (mode == eeprom_pkg::cmd_read_byte);
  assign last_bit = (bit_cnt == BIT_W'(`EE_DATA_W));

  assign sda     = sda_low ? 1'b0 : 1'bz;  // open drain
  assign rx_byte = shift;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      mode    <= eeprom_pkg::cmd_stop;
      cnt     <= '0;
      bit_cnt <= '0;
      scl     <= 1'b1;
      sda_low <= 1'b0;
      done    <= 1'b0;
      nack    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (cmd_valid) begin
          busy    <= 1'b1;
          mode    <= cmd;
          cnt     <= '0;
          bit_cnt <= '0;
        end
      end else begin
        cnt <= (cnt == LAST_PT) ? '0 : cnt + 1'b1;

        if (cnt == '0)
          scl <= 1'b0;
        if (cnt == RISE_PT)
          scl <= 1'b1;

        // quarter point, scl is low here
        if (cnt == DRIVE_PT) begin
          case (mode)
            eeprom_pkg::cmd_start:      sda_low <= 1'b0;  // sda high before the start edge
            eeprom_pkg::cmd_stop:       sda_low <= 1'b1;
            eeprom_pkg::cmd_write_byte: sda_low <= !last_bit && !shift[`EE_DATA_W-1];
            default:                    sda_low <= 1'b0;  // read bits and our nack
          endcase
        end

        // middle of scl high
        if (cnt == SAMPLE_PT) begin
          case (mode)
            eeprom_pkg::cmd_start: sda_low <= 1'b1;  // start condition
            eeprom_pkg::cmd_stop:  sda_low <= 1'b0;  // stop condition
            default: begin
              if (last_bit)
                nack <= sda;
            end
          endcase
        end

        if (cnt == LAST_PT) begin
          if (is_byte && !last_bit) begin
            bit_cnt <= bit_cnt + 1'b1;
          end else begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end
      end
    end
  end

  // tx byte leaves msb first, received bits enter at the lsb
  always_ff @(posedge clk) begin
    if (!busy && cmd_valid)
      shift <= tx_byte;
    else if (busy && is_byte && !last_bit && cnt == SAMPLE_PT)
      shift <= {shift[`EE_DATA_W-2:0], sda};
  end

  // one command in flight at a time
  a_cmd_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid |-> !busy)
    else $error("serial_engine: command issued while busy");

  // data may move only with scl low, start and stop excepted
  a_sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (scl && $past(scl) &&
     !($past(busy) && ($past(mode) inside {eeprom_pkg::cmd_start, eeprom_pkg::cmd_stop})))
    |-> $stable(sda))
    else $error("serial_engine: sda changed while scl high");

endmodule

// File: verilog.f
+incdir+common
common/eeprom_pkg.sv
hw/eeprom_wr/serial_engine.sv
hw/eeprom_wr/eeprom_wr.sv
hw/eeprom_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_top.sv
